//--- flist.f
src/regReadPkg.sv
src/physRegFile.sv
src/readyScoreboard.sv
src/regReadLane.sv
src/regReadStage.sv
verif/regReadChecker.sv
verif/regRead_asserts.sv
verif/tbRegRead.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tbRegRead
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation completed successfully
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "sim: FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "sim: run ended before the closing line"; exit 1; \
	else \
	  echo "sim: PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tbRegRead.sv
// ==============================
// testbench top for the register-read stage
// drives directed phases, a parallel-lane burst and a long
// random run while the monitor checks every result
// ==============================
`timescale 1ns/100ps
`default_nettype none

module tbRegRead
  import regReadPkg::*;
;

  logic                   clk;
  logic                   arstN_i;
  issuePkt_t              issue_i [NumLanes];
  logic [NumLanes-1:0]    issueValid_i;
  bypassPkt_t             bypass_i [NumLanes];
  tagPkt_t                unmap_i [NumLanes];
  tagPkt_t                wakeup_i [NumLanes];
  mispredictPkt_t         mispredict_i;
  readPkt_t               read_o [NumLanes];
  logic [NumLanes-1:0]    readValid_o;
  logic [NumPhysRegs-1:0] physRegReady_o;
  int                     timeoutErrors;
  int                     totalErrors;

  always #5 clk = ~clk;

  regReadStage u_regReadStage (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .issue_i        (issue_i),
    .issueValid_i   (issueValid_i),
    .bypass_i       (bypass_i),
    .unmap_i        (unmap_i),
    .wakeup_i       (wakeup_i),
    .mispredict_i   (mispredict_i),
    .read_o         (read_o),
    .readValid_o    (readValid_o),
    .physRegReady_o (physRegReady_o)
  );

  regReadChecker u_regReadChecker (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .issue_i        (issue_i),
    .issueValid_i   (issueValid_i),
    .bypass_i       (bypass_i),
    .unmap_i        (unmap_i),
    .wakeup_i       (wakeup_i),
    .mispredict_i   (mispredict_i),
    .read_i         (read_o),
    .readValid_i    (readValid_o),
    .physRegReady_i (physRegReady_o)
  );

  bind regReadStage regRead_asserts u_regReadAsserts (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .issue_i        (issue_i),
    .mispredict_i   (mispredict_i),
    .wakeup_i       (wakeup_i),
    .readValid_i    (readValid_o),
    .physRegReady_i (physRegReady_o)
  );

  // a narrow pool of tags keeps bypass hits frequent
  function automatic physTag_t poolTag();
    return physTag_t'(($urandom % 8) * 8 + 1);
  endfunction

  task idleInputs();
    for (int l = 0; l < NumLanes; l++)
    begin
      issue_i[l] <= '0;
      bypass_i[l] <= '0;
      unmap_i[l] <= '0;
      wakeup_i[l] <= '0;
    end
    issueValid_i <= '0;
    mispredict_i <= '0;
  endtask

  task startCycle();
    @(posedge clk);
    idleInputs();
  endtask

  task issueLane(input int lane, input logic [NumCkpts-1:0] mask,
                 input physTag_t s1, input physTag_t s2);
    issue_i[lane] <= '{brMask: mask, src1: s1, src2: s2, dest: poolTag(),
                       alIdx: AlIdxW'($urandom)};
    issueValid_i[lane] <= 1'b1;
  endtask

  task writeBypass(input int port, input physTag_t dest, input data_t data);
    bypass_i[port] <= '{valid: 1'b1, dest: dest, data: data};
  endtask

  task waitForValid(input int lane, input int limit);
    int cycles;
    cycles = 0;
    startCycle();
    do
    begin
      @(negedge clk);
      cycles++;
    end while ((readValid_o[lane] !== 1'b1) && (cycles < limit));
    if (readValid_o[lane] !== 1'b1)
    begin
      timeoutErrors++;
      $display("Timed out after %0d cycles waiting for a result on lane %0d", limit, lane);
    end
  endtask

  task waitForReady(input physTag_t tag, input int limit);
    int cycles;
    cycles = 0;
    startCycle();
    do
    begin
      @(negedge clk);
      cycles++;
    end while ((physRegReady_o[tag] !== 1'b1) && (cycles < limit));
    if (physRegReady_o[tag] !== 1'b1)
    begin
      timeoutErrors++;
      $display("Timed out after %0d cycles waiting for register %0d to become ready",
               limit, tag);
    end
  endtask

  task randomCycle(input logic allValid);
    for (int l = 0; l < NumLanes; l++)
    begin
      if (allValid || (($urandom % 4) != 0))
        issueLane(l, NumCkpts'($urandom), poolTag(), poolTag());
    end
    for (int p = 0; p < NumLanes; p++)
    begin
      if (($urandom % 2) != 0)
        writeBypass(p, poolTag(), $urandom);
      if (($urandom % 4) == 0)
        unmap_i[p] <= '{valid: 1'b1, tag: physTag_t'($urandom)};
      if (($urandom % 4) == 0)
        wakeup_i[p] <= '{valid: 1'b1, tag: physTag_t'($urandom)};
    end
    if (!allValid && (($urandom % 8) == 0))
      mispredict_i <= '{valid: 1'b1, ckptId: CkptW'($urandom)};
  endtask

  initial
  begin
    void'($urandom(32'h29ec_dc21));
    clk = 1'b0;
    arstN_i = 1'b0;
    timeoutErrors = 0;
    idleInputs();
    repeat (5) @(posedge clk);
    arstN_i <= 1'b1;
    startCycle();

    // untouched registers read back as zero
    startCycle();
    issueLane(0, '0, 6'd5, 6'd40);
    waitForValid(0, 4);

    startCycle();
    writeBypass(0, 6'd3, 32'hdead_0003);
    writeBypass(1, 6'd50, 32'h1234_5678);
    startCycle();
    startCycle();
    issueLane(1, '0, 6'd3, 6'd50);
    issueLane(2, '0, 6'd50, 6'd3);
    waitForValid(1, 4);

    // ports 1 and 2 collide on register 7 and port 1 must be seen now and from the file later
    startCycle();
    writeBypass(1, 6'd7, 32'haaaa_0001);
    writeBypass(2, 6'd7, 32'hbbbb_0002);
    writeBypass(3, 6'd8, 32'hcccc_0003);
    issueLane(0, '0, 6'd7, 6'd8);
    issueLane(3, '0, 6'd8, 6'd7);
    startCycle();
    issueLane(1, '0, 6'd7, 6'd7);
    waitForValid(1, 4);

    startCycle();
    mispredict_i <= '{valid: 1'b1, ckptId: CkptW'(2)};
    issueLane(0, 4'b0100, 6'd3, 6'd7);
    issueLane(1, 4'b0000, 6'd7, 6'd3);
    issueLane(2, 4'b1100, 6'd50, 6'd8);
    issueLane(3, 4'b0011, 6'd8, 6'd50);
    waitForValid(1, 4);

    startCycle();
    unmap_i[0] <= '{valid: 1'b1, tag: 6'd10};
    unmap_i[1] <= '{valid: 1'b1, tag: 6'd12};
    wakeup_i[2] <= '{valid: 1'b1, tag: 6'd33};
    wakeup_i[3] <= '{valid: 1'b1, tag: 6'd12};
    waitForReady(6'd33, 4);

    repeat (20)
    begin
      startCycle();
      randomCycle(1'b1);
    end
    repeat (2000)
    begin
      startCycle();
      randomCycle(1'b0);
    end
    startCycle();
    @(negedge clk);
    @(negedge clk);

    totalErrors = u_regReadChecker.dataErrors + u_regReadChecker.validErrors +
                  u_regReadChecker.readyErrors + timeoutErrors;
    $display("Checked %0d packets, errors: data %0d, valid %0d, ready %0d, timeout %0d",
             u_regReadChecker.packetsChecked, u_regReadChecker.dataErrors,
             u_regReadChecker.validErrors, u_regReadChecker.readyErrors, timeoutErrors);
    if (totalErrors == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/regRead_asserts.sv
// ==============================
// concurrent properties of the register-read stage
// bound into the top level by the testbench
// ==============================
`timescale 1ns/100ps
`default_nettype none

module regRead_asserts
  import regReadPkg::*;
(
  input wire logic                   clk,
  input wire logic                   arstN_i,
  input wire issuePkt_t              issue_i [NumLanes],
  input wire mispredictPkt_t         mispredict_i,
  input wire tagPkt_t                wakeup_i [NumLanes],
  input wire logic [NumLanes-1:0]    readValid_i,
  input wire logic [NumPhysRegs-1:0] physRegReady_i
);

  quietInReset: assert property (@(posedge clk) !arstN_i |-> (readValid_i == '0))
    else $error("readValid_o is high while reset is asserted");

  quietAfterReset: assert property (@(posedge clk) $rose(arstN_i) |-> (readValid_i == '0))
    else $error("readValid_o is high on the first edge after reset");

  for (genvar l = 0; l < NumLanes; l++)
  begin : g_laneProps
    squashKills: assert property (@(posedge clk) disable iff (!arstN_i)
      (mispredict_i.valid && issue_i[l].brMask[mispredict_i.ckptId]) |=> !readValid_i[l])
      else $error("lane %0d presented a result after being squashed", l);
  end

  for (genvar p = 0; p < NumLanes; p++)
  begin : g_wakeProps
    wakeSetsReady: assert property (@(posedge clk) disable iff (!arstN_i)
      wakeup_i[p].valid |=> physRegReady_i[$past(wakeup_i[p].tag)])
      else $error("register woken on port %0d is not ready a cycle later", p);
  end

endmodule

`default_nettype wire

//--- verif/regReadChecker.sv
// ==============================
// monitor for the register-read stage
// keeps a shadow file and ready table, predicts each
// lane output and compares on the falling edge
// ==============================
`timescale 1ns/100ps
`default_nettype none

module regReadChecker
  import regReadPkg::*;
(
  input wire logic                   clk,
  input wire logic                   arstN_i,
  input wire issuePkt_t              issue_i [NumLanes],
  input wire logic [NumLanes-1:0]    issueValid_i,
  input wire bypassPkt_t             bypass_i [NumLanes],
  input wire tagPkt_t                unmap_i [NumLanes],
  input wire tagPkt_t                wakeup_i [NumLanes],
  input wire mispredictPkt_t         mispredict_i,
  input wire readPkt_t               read_i [NumLanes],
  input wire logic [NumLanes-1:0]    readValid_i,
  input wire logic [NumPhysRegs-1:0] physRegReady_i
);

  data_t                  shadowRegs [NumPhysRegs];
  logic [NumPhysRegs-1:0] shadowReady;
  readPkt_t               expRead [NumLanes];
  logic [NumLanes-1:0]    expValid;
  logic                   primed = 1'b0;
  int                     dataErrors = 0;
  int                     validErrors = 0;
  int                     readyErrors = 0;
  int                     packetsChecked = 0;

  // first valid writeback port naming the tag wins, else the file value
  function automatic data_t operandFor(physTag_t tag);
    data_t value;
    logic  hit;
    value = shadowRegs[tag];
    hit = 1'b0;
    for (int p = 0; p < NumLanes; p++)
    begin
      if (!hit && bypass_i[p].valid && (bypass_i[p].dest == tag))
      begin
        value = bypass_i[p].data;
        hit = 1'b1;
      end
    end
    return value;
  endfunction

  function automatic readPkt_t expectRead(input int lane, output logic valid);
    readPkt_t pkt;
    pkt.src1Data = operandFor(issue_i[lane].src1);
    pkt.src2Data = operandFor(issue_i[lane].src2);
    pkt.issue    = issue_i[lane];
    valid = issueValid_i[lane] &&
            !(mispredict_i.valid && issue_i[lane].brMask[mispredict_i.ckptId]);
    return pkt;
  endfunction

  // inputs are still at their pre-edge values here
  always @(posedge clk)
  begin : modelUpdate
    logic [NumPhysRegs-1:0] claimed;
    logic                   laneValid;
    if (!arstN_i)
    begin
      for (int r = 0; r < NumPhysRegs; r++)
      begin
        shadowRegs[r] = '0;
        shadowReady[r] = (r < NumArchRegs);
      end
      expValid = '0;
    end
    else
    begin
      for (int l = 0; l < NumLanes; l++)
      begin
        expRead[l] = expectRead(l, laneValid);
        expValid[l] = laneValid;
      end
      claimed = '0;
      for (int p = 0; p < NumLanes; p++)
      begin
        if (bypass_i[p].valid && !claimed[bypass_i[p].dest])
        begin
          shadowRegs[bypass_i[p].dest] = bypass_i[p].data;
          claimed[bypass_i[p].dest] = 1'b1;
        end
      end
      for (int p = 0; p < NumLanes; p++)
      begin
        if (unmap_i[p].valid)
          shadowReady[unmap_i[p].tag] = 1'b0;
      end
      for (int p = 0; p < NumLanes; p++)
      begin
        if (wakeup_i[p].valid)
          shadowReady[wakeup_i[p].tag] = 1'b1;
      end
    end
    primed = 1'b1;
  end

  always @(negedge clk)
  begin
    if (primed)
    begin
      for (int l = 0; l < NumLanes; l++)
      begin
        if (readValid_i[l] !== expValid[l])
        begin
          validErrors++;
          $display("Mismatch at %0t: lane %0d readValid_o is %b, expected %b",
                   $time, l, readValid_i[l], expValid[l]);
        end
        else if (expValid[l])
        begin
          packetsChecked++;
          if (read_i[l] !== expRead[l])
          begin
            dataErrors++;
            $display("Mismatch at %0t: lane %0d read_o is %h, expected %h",
                     $time, l, read_i[l], expRead[l]);
          end
        end
      end
      if (physRegReady_i !== shadowReady)
      begin
        readyErrors++;
        $display("Mismatch at %0t: physRegReady_o is %h, expected %h",
                 $time, physRegReady_i, shadowReady);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/regReadStage.sv
// ==============================
// register-read stage of a four-wide out-of-order core
// no stall, every lane accepts one instruction per cycle
// and presents it with operands one cycle later
// ==============================
`timescale 1ns/100ps
`default_nettype none

module regReadStage
  import regReadPkg::*;
(
  input  wire logic           clk,
  input  wire logic           arstN_i,

  input  wire issuePkt_t      issue_i [NumLanes],
  input  wire logic [NumLanes-1:0] issueValid_i,
  input  wire bypassPkt_t     bypass_i [NumLanes],
  input  wire tagPkt_t        unmap_i [NumLanes],
  input  wire tagPkt_t        wakeup_i [NumLanes],
  input  wire mispredictPkt_t mispredict_i,

  output readPkt_t            read_o [NumLanes],
  output logic [NumLanes-1:0] readValid_o,
  output logic [NumPhysRegs-1:0] physRegReady_o
);

  // read port 2*l carries source 1 of lane l, port 2*l+1 source 2
  physTag_t rdTag [2*NumLanes];
  data_t    rdData [2*NumLanes];

  physRegFile u_physRegFile (
    .clk      (clk),
    .arstN_i  (arstN_i),
    .bypass_i (bypass_i),
    .rdTag_i  (rdTag),
    .rdData_o (rdData)
  );

  readyScoreboard u_readyScoreboard (
    .clk            (clk),
    .arstN_i        (arstN_i),
    .unmap_i        (unmap_i),
    .wakeup_i       (wakeup_i),
    .physRegReady_o (physRegReady_o)
  );

  for (genvar l = 0; l < NumLanes; l++)
  begin : g_lane
    data_t laneData [2];

    assign rdTag[2*l]     = issue_i[l].src1;
    assign rdTag[2*l + 1] = issue_i[l].src2;
    assign laneData[0]    = rdData[2*l];
    assign laneData[1]    = rdData[2*l + 1];

    regReadLane u_regReadLane (
      .clk          (clk),
      .arstN_i      (arstN_i),
      .issue_i      (issue_i[l]),
      .issueValid_i (issueValid_i[l]),
      .fileData_i   (laneData),
      .bypass_i     (bypass_i),
      .mispredict_i (mispredict_i),
      .read_o       (read_o[l]),
      .readValid_o  (readValid_o[l])
    );
  end

endmodule

`default_nettype wire

//--- src/regReadLane.sv
// ==============================
// one issue lane of the register-read stage
// picks file or bypass data per source, squashes on a
// matching mispredict and registers the packet once
// ==============================
`timescale 1ns/100ps
`default_nettype none

module regReadLane
  import regReadPkg::*;
(
  input  wire logic           clk,
  input  wire logic           arstN_i,
  input  wire issuePkt_t      issue_i,
  input  wire logic           issueValid_i,
  input  wire data_t          fileData_i [2],
  input  wire bypassPkt_t     bypass_i [NumLanes],
  input  wire mispredictPkt_t mispredict_i,
  output readPkt_t            read_o,
  output logic                readValid_o
);

  physTag_t srcTag [2];
  data_t    srcData [2];
  readPkt_t readNext;
  logic     squash;

  assign srcTag[0] = issue_i.src1;
  assign srcTag[1] = issue_i.src2;

  // lowest-numbered matching port wins, so scan downward and let port 0 overwrite last
  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      srcData[s] = fileData_i[s];
      for (int p = NumLanes - 1; p >= 0; p--)
      begin
        if (bypass_i[p].valid && (bypass_i[p].dest == srcTag[s]))
        begin
          srcData[s] = bypass_i[p].data;
        end
      end
    end
  end

  // the instruction sits on the wrong path if it depends on the mispredicted checkpoint
  assign squash = mispredict_i.valid && issue_i.brMask[mispredict_i.ckptId];

  always_comb
  begin
    readNext.src1Data = srcData[0];
    readNext.src2Data = srcData[1];
    readNext.issue    = issue_i;
  end

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      readValid_o <= 1'b0;
    end
    else
    begin
      readValid_o <= issueValid_i && !squash;
    end
  end

  always_ff @(posedge clk)
  begin
    read_o <= readNext;
  end

endmodule

`default_nettype wire

//--- src/readyScoreboard.sv
// ==============================
// one ready bit per physical register
// unmap clears a bit, wakeup sets it, result is exported
// ==============================
`timescale 1ns/100ps
`default_nettype none

module readyScoreboard
  import regReadPkg::*;
(
  input  wire logic             clk,
  input  wire logic             arstN_i,
  input  wire tagPkt_t          unmap_i [NumLanes],
  input  wire tagPkt_t          wakeup_i [NumLanes],
  output logic [NumPhysRegs-1:0] physRegReady_o
);

  logic [NumPhysRegs-1:0] readyNext;

  // clears go first so a wakeup to the same register overrides the unmap
  always_comb
  begin
    readyNext = physRegReady_o;
    for (int p = 0; p < NumLanes; p++)
    begin
      if (unmap_i[p].valid)
      begin
        readyNext[unmap_i[p].tag] = 1'b0;
      end
    end
    for (int p = 0; p < NumLanes; p++)
    begin
      if (wakeup_i[p].valid)
      begin
        readyNext[wakeup_i[p].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      // the architectural registers hold committed values out of reset
      for (int r = 0; r < NumPhysRegs; r++)
      begin
        physRegReady_o[r] <= (r < NumArchRegs);
      end
    end
    else
    begin
      physRegReady_o <= readyNext;
    end
  end

endmodule

`default_nettype wire

//--- src/physRegFile.sv
// ==============================
// 64 x 32 physical register file built from flops
// four writeback ports, two combinational reads per lane
// ==============================
`timescale 1ns/100ps
`default_nettype none

module physRegFile
  import regReadPkg::*;
(
  input  wire logic       clk,
  input  wire logic       arstN_i,
  input  wire bypassPkt_t bypass_i [NumLanes],
  input  wire physTag_t   rdTag_i [2*NumLanes],
  output data_t           rdData_o [2*NumLanes]
);

  data_t regs [NumPhysRegs];

  always_ff @(posedge clk or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      for (int r = 0; r < NumPhysRegs; r++)
      begin
        regs[r] <= '0;
      end
    end
    else
    begin
      // walk from the top port down so port 0 is applied last and wins a collision,
      // the same priority the lanes use for forwarding
      for (int p = NumLanes - 1; p >= 0; p--)
      begin
        if (bypass_i[p].valid)
        begin
          regs[bypass_i[p].dest] <= bypass_i[p].data;
        end
      end
    end
  end

  // reads see state only, same-cycle writes come in through the lane bypass
  always_comb
  begin
    for (int i = 0; i < 2*NumLanes; i++)
    begin
      rdData_o[i] = regs[rdTag_i[i]];
    end
  end

endmodule

`default_nettype wire

//--- src/regReadPkg.sv
// ==============================
// sizes and packet types shared by the register-read stage
// imported by every RTL module and the testbench
// ==============================
`default_nettype none

package regReadPkg;

  // machine sizes
  localparam int NumLanes    = 4;
  localparam int NumPhysRegs = 64;
  localparam int PhysRegW    = $clog2(NumPhysRegs);
  localparam int DataW       = 32;
  localparam int NumArchRegs = 32;
  localparam int NumCkpts    = 4;
  localparam int CkptW       = $clog2(NumCkpts);
  localparam int AlIdxW      = 7;

  typedef logic [PhysRegW-1:0] physTag_t;
  typedef logic [DataW-1:0]    data_t;

  // one issued instruction as it leaves the issue queue
  typedef struct packed {
    logic [NumCkpts-1:0] brMask;
    physTag_t            src1;
    physTag_t            src2;
    physTag_t            dest;
    logic [AlIdxW-1:0]   alIdx;
  } issuePkt_t;

  // one writeback port, also the source of forwarded operands
  typedef struct packed {
    logic     valid;
    physTag_t dest;
    data_t    data;
  } bypassPkt_t;

  // unmap or wakeup request for the ready table
  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } tagPkt_t;

  typedef struct packed {
    logic             valid;
    logic [CkptW-1:0] ckptId;
  } mispredictPkt_t;

  // what a lane hands to its functional unit
  typedef struct packed {
    data_t     src1Data;
    data_t     src2Data;
    issuePkt_t issue;
  } readPkt_t;

endpackage

`default_nettype wire
